//--- hw/cp0_regs.sv
`timescale 1ns/100ps
`include "mem_macros.svh"

module cp0_regs (
  input  logic               clk,
  input  logic               rst,
  input  cpu_pkg::cp0_wr_t   wr_i,
  input  logic [5:0]         hw_int_i,
  input  cpu_pkg::exc_code_e code_i,
  input  logic [`REG_W-1:0]  pc_i,
  input  logic               in_delay_i,
  output logic [`REG_W-1:0]  status_o,
  output logic [`REG_W-1:0]  cause_o,
  output logic [`REG_W-1:0]  epc_o
);
  import cpu_pkg::*;

  logic [`REG_W-1:0] status_q;
  logic [`REG_W-1:0] cause_q;
  logic [`REG_W-1:0] epc_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      status_q <= '0;
      cause_q  <= '0;
      epc_q    <= '0;
    end else begin
      // hardware interrupt lines land in IP7..IP2
      cause_q[15:10] <= hw_int_i;

      if (wr_i.we) begin
        case (wr_i.addr)
          `CP0_STATUS: status_q <= wr_i.data;
          `CP0_CAUSE: begin
            // only IP1..IP0, WP and IV are writable
            cause_q[9:8] <= wr_i.data[9:8];
            cause_q[22]  <= wr_i.data[22];
            cause_q[23]  <= wr_i.data[23];
          end
          `CP0_EPC: epc_q <= wr_i.data;
          default: ;
        endcase
      end

      // exception entry overrides the older software write
      if (code_i == EXC_ERET) begin
        status_q[1] <= 1'b0;
      end else if (code_i != EXC_NONE) begin
        status_q[1]   <= 1'b1;
        cause_q[6:2]  <= code_i;
        cause_q[31]   <= in_delay_i;
        epc_q         <= in_delay_i ? pc_i - 32'd4 : pc_i;
      end
    end
  end

  assign status_o = status_q;
  assign cause_o  = cause_q;
  assign epc_o    = epc_q;

endmodule

//--- hw/cpu_pkg.sv
`include "mem_macros.svh"

package cpu_pkg;

  typedef enum logic [3:0] {
    MEM_NONE,
    MEM_LB,
    MEM_LBU,
    MEM_LH,
    MEM_LHU,
    MEM_LW,
    MEM_SB,
    MEM_SH,
    MEM_SW
  } mem_op_e;

  typedef enum logic [4:0] {
    EXC_NONE = 5'd0,
    EXC_INT  = 5'd1,
    EXC_SYS  = 5'd8,
    EXC_RI   = 5'd10,
    EXC_OV   = 5'd12,
    EXC_TR   = 5'd13,
    EXC_ERET = 5'd14
  } exc_code_e;

  // pending flags raised by decode and execute
  typedef struct packed {
    logic syscall;
    logic invalid;
    logic trap;
    logic overflow;
    logic eret;
  } exc_flags_t;

  typedef struct packed {
    logic                  we;
    logic [`REGADDR_W-1:0] addr;
    logic [`REG_W-1:0]     data;
  } cp0_wr_t;

  typedef struct packed {
    logic                  valid;
    logic [`REGADDR_W-1:0] wd;
    logic                  wreg;
    logic [`REG_W-1:0]     wdata;
    logic                  whilo;
    logic [`REG_W-1:0]     hi;
    logic [`REG_W-1:0]     lo;
    cp0_wr_t               cp0;
    exc_flags_t            exc;
    logic                  in_delay;
    logic [`REG_W-1:0]     pc;
    mem_op_e               op;
    logic [`REG_W-1:0]     mem_addr;
    logic [`REG_W-1:0]     reg2;
  } ex_mem_t;

  typedef struct packed {
    logic                  valid;
    logic [`REGADDR_W-1:0] wd;
    logic                  wreg;
    logic [`REG_W-1:0]     wdata;
    logic                  whilo;
    logic [`REG_W-1:0]     hi;
    logic [`REG_W-1:0]     lo;
    cp0_wr_t               cp0;
  } mem_wb_t;

  // size: 0 byte, 1 halfword, 2 word
  typedef struct packed {
    logic              req;
    logic              wr;
    logic [1:0]        size;
    logic [`REG_W-1:0] addr;
    logic [`REG_W-1:0] wdata;
  } bus_req_t;

endpackage

//--- hw/data_ram.sv
`timescale 1ns/100ps
`include "mem_macros.svh"

module data_ram (
  input  logic              clk,
  input  logic              rst,
  input  cpu_pkg::bus_req_t bus_i,
  output logic              addr_ok_o,
  output logic              data_ok_o,
  output logic [`REG_W-1:0] rdata_o
);

  localparam int AW = $clog2(`RAM_WORDS);

  logic [`REG_W-1:0] mem [`RAM_WORDS];
  logic [`REG_W-1:0] rdata_q;
  logic              data_ok_q;
  logic              accept;
  logic [AW-1:0]     idx;
  logic [3:0]        be;

  // always ready, so accept in the request cycle
  assign addr_ok_o = bus_i.req;
  assign accept    = bus_i.req && addr_ok_o;
  assign idx       = bus_i.addr[AW+1:2];

  // be[3] is offset 0, bits 31:24
  always_comb begin
    case (bus_i.size)
      2'd0:    be = 4'b1000 >> bus_i.addr[1:0];
      2'd1:    be = bus_i.addr[1] ? 4'b0011 : 4'b1100;
      default: be = 4'b1111;
    endcase
  end

  always_ff @(posedge clk) begin
    if (accept && bus_i.wr) begin
      for (int i = 0; i < 4; i++) begin
        if (be[i]) begin
          mem[idx][8*i +: 8] <= bus_i.wdata[8*i +: 8];
        end
      end
    end
    if (accept && !bus_i.wr) begin
      rdata_q <= mem[idx];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      data_ok_q <= 1'b0;
    end else begin
      data_ok_q <= accept;
    end
  end

  assign data_ok_o = data_ok_q;
  assign rdata_o   = rdata_q;

endmodule

//--- hw/exc_resolve.sv
`timescale 1ns/100ps
`include "mem_macros.svh"

module exc_resolve (
  input  cpu_pkg::ex_mem_t   ex_i,
  input  logic [`REG_W-1:0]  status_i,
  input  logic [`REG_W-1:0]  cause_i,
  input  logic [`REG_W-1:0]  epc_i,
  input  cpu_pkg::cp0_wr_t   wb_cp0_i,
  output cpu_pkg::exc_code_e code_o,
  output logic [`REG_W-1:0]  epc_o
);
  import cpu_pkg::*;

  logic [`REG_W-1:0] status;
  logic [`REG_W-1:0] cause;
  logic              int_pend;

  // same-cycle writeback cp0 write wins over the register value
  always_comb begin
    status = status_i;
    cause  = cause_i;
    epc_o  = epc_i;
    if (wb_cp0_i.we) begin
      case (wb_cp0_i.addr)
        `CP0_STATUS: status = wb_cp0_i.data;
        `CP0_CAUSE: begin
          cause[9:8] = wb_cp0_i.data[9:8];
          cause[22]  = wb_cp0_i.data[22];
          cause[23]  = wb_cp0_i.data[23];
        end
        `CP0_EPC: epc_o = wb_cp0_i.data;
        default: ;
      endcase
    end
  end

  // masked IP, IE set and EXL clear
  assign int_pend = (|(cause[15:8] & status[15:8])) && status[0] && !status[1];

  always_comb begin
    code_o = EXC_NONE;
    if (ex_i.valid) begin
      if (int_pend) begin
        code_o = EXC_INT;
      end else if (ex_i.exc.syscall) begin
        code_o = EXC_SYS;
      end else if (ex_i.exc.invalid) begin
        code_o = EXC_RI;
      end else if (ex_i.exc.trap) begin
        code_o = EXC_TR;
      end else if (ex_i.exc.overflow) begin
        code_o = EXC_OV;
      end else if (ex_i.exc.eret) begin
        code_o = EXC_ERET;
      end
    end
  end

endmodule

//--- hw/mem_access.sv
`timescale 1ns/100ps
`include "mem_macros.svh"

module mem_access (
  input  logic              clk,
  input  logic              rst,
  input  cpu_pkg::ex_mem_t  ex_i,
  input  logic              kill_i,
  output cpu_pkg::bus_req_t bus_o,
  input  logic              addr_ok_i,
  input  logic              data_ok_i,
  input  logic [`REG_W-1:0] rdata_i,
  output logic              stall_o,
  output cpu_pkg::mem_wb_t  wb_o
);
  import cpu_pkg::*;

  logic              waiting_q;
  logic              is_load;
  logic              is_store;
  logic [1:0]        off;
  logic [7:0]        rd_byte;
  logic [15:0]       rd_half;
  logic [`REG_W-1:0] load_data;

  assign is_load  = ex_i.op inside {MEM_LB, MEM_LBU, MEM_LH, MEM_LHU, MEM_LW};
  assign is_store = ex_i.op inside {MEM_SB, MEM_SH, MEM_SW};
  assign off      = ex_i.mem_addr[1:0];

  // new request only from idle
  always_comb begin
    bus_o.req  = ex_i.valid && (is_load || is_store) && !kill_i && !waiting_q;
    bus_o.wr   = is_store;
    bus_o.addr = ex_i.mem_addr;
    case (ex_i.op)
      MEM_LB, MEM_LBU, MEM_SB: begin
        bus_o.size  = 2'd0;
        bus_o.wdata = {4{ex_i.reg2[7:0]}};
      end
      MEM_LH, MEM_LHU, MEM_SH: begin
        bus_o.size  = 2'd1;
        bus_o.wdata = {2{ex_i.reg2[15:0]}};
      end
      default: begin
        bus_o.size  = 2'd2;
        bus_o.wdata = ex_i.reg2;
      end
    endcase
  end

  assign stall_o = bus_o.req || (waiting_q && !data_ok_i);

  always_ff @(posedge clk) begin
    if (rst) begin
      waiting_q <= 1'b0;
    end else if (bus_o.req && addr_ok_i) begin
      waiting_q <= 1'b1;
    end else if (data_ok_i) begin
      waiting_q <= 1'b0;
    end
  end

  // big-endian lanes, offset 0 is the top byte
  always_comb begin
    case (off)
      2'd0:    rd_byte = rdata_i[31:24];
      2'd1:    rd_byte = rdata_i[23:16];
      2'd2:    rd_byte = rdata_i[15:8];
      default: rd_byte = rdata_i[7:0];
    endcase
  end

  assign rd_half = off[1] ? rdata_i[15:0] : rdata_i[31:16];

  always_comb begin
    case (ex_i.op)
      MEM_LB:  load_data = {{24{rd_byte[7]}}, rd_byte};
      MEM_LBU: load_data = {24'd0, rd_byte};
      MEM_LH:  load_data = {{16{rd_half[15]}}, rd_half};
      MEM_LHU: load_data = {16'd0, rd_half};
      MEM_LW:  load_data = rdata_i;
      default: load_data = ex_i.wdata;
    endcase
  end

  // a killed instruction still flows, but writes nothing
  always_comb begin
    wb_o.valid  = ex_i.valid;
    wb_o.wd     = ex_i.wd;
    wb_o.wreg   = ex_i.wreg && !kill_i;
    wb_o.wdata  = load_data;
    wb_o.whilo  = ex_i.whilo && !kill_i;
    wb_o.hi     = ex_i.hi;
    wb_o.lo     = ex_i.lo;
    wb_o.cp0    = ex_i.cp0;
    wb_o.cp0.we = ex_i.cp0.we && !kill_i;
  end

endmodule

//--- hw/mem_macros.svh
`ifndef MEM_MACROS_SVH
`define MEM_MACROS_SVH

// datapath widths
`define REG_W      32
`define REGADDR_W  5

// cp0 register numbers
`define CP0_STATUS 5'd12
`define CP0_CAUSE  5'd13
`define CP0_EPC    5'd14

// data ram depth in words
`define RAM_WORDS  256

`endif

//--- hw/mem_stage_top.sv
`timescale 1ns/100ps
`include "mem_macros.svh"

module mem_stage_top (
  input  logic               clk,
  input  logic               rst,
  input  cpu_pkg::ex_mem_t   ex_i,
  input  logic [5:0]         hw_int_i,
  output cpu_pkg::mem_wb_t   wb_o,
  output cpu_pkg::exc_code_e exc_code_o,
  output logic [`REG_W-1:0]  epc_o,
  output logic               flush_o,
  output logic               stall_o
);
  import cpu_pkg::*;

  ex_mem_t           ex_q;
  mem_wb_t           wb_d;
  bus_req_t          bus;
  logic              addr_ok;
  logic              data_ok;
  logic [`REG_W-1:0] rdata;
  logic [`REG_W-1:0] cp0_status;
  logic [`REG_W-1:0] cp0_cause;
  logic [`REG_W-1:0] cp0_epc;

  assign flush_o = (exc_code_o != EXC_NONE);

  pipe_reg #(.payload_t(ex_mem_t)) i_ex_mem (
    .clk(clk), .rst(rst), .hold_i(stall_o), .clear_i(1'b0), .d_i(ex_i), .q_o(ex_q)
  );

  mem_access i_mem_access (
    .clk(clk), .rst(rst), .ex_i(ex_q), .kill_i(flush_o), .bus_o(bus),
    .addr_ok_i(addr_ok), .data_ok_i(data_ok), .rdata_i(rdata),
    .stall_o(stall_o), .wb_o(wb_d)
  );

  // stalled slot becomes a bubble in writeback
  pipe_reg #(.payload_t(mem_wb_t)) i_mem_wb (
    .clk(clk), .rst(rst), .hold_i(1'b0), .clear_i(stall_o), .d_i(wb_d), .q_o(wb_o)
  );

  exc_resolve i_exc_resolve (
    .ex_i(ex_q), .status_i(cp0_status), .cause_i(cp0_cause), .epc_i(cp0_epc),
    .wb_cp0_i(wb_o.cp0), .code_o(exc_code_o), .epc_o(epc_o)
  );

  cp0_regs i_cp0_regs (
    .clk(clk), .rst(rst), .wr_i(wb_o.cp0), .hw_int_i(hw_int_i), .code_i(exc_code_o),
    .pc_i(ex_q.pc), .in_delay_i(ex_q.in_delay), .status_o(cp0_status),
    .cause_o(cp0_cause), .epc_o(cp0_epc)
  );

  data_ram i_data_ram (
    .clk(clk), .rst(rst), .bus_i(bus), .addr_ok_o(addr_ok), .data_ok_o(data_ok),
    .rdata_o(rdata)
  );

endmodule

//--- hw/pipe_reg.sv
`timescale 1ns/100ps

module pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     hold_i,
  input  logic     clear_i,
  input  payload_t d_i,
  output payload_t q_o
);

  payload_t q_r;

  // all-zero payload reads as not valid
  always_ff @(posedge clk) begin
    if (rst || clear_i) begin
      q_r <= '0;
    end else if (!hold_i) begin
      q_r <= d_i;
    end
  end

  assign q_o = q_r;

endmodule

//--- run.sh
#!/bin/sh
# builds and runs the memory stage testbench, the log decides pass or fail
rm -rf obj_dir sim.log
{ verilator --binary --timing --assert -f sim.f --top-module mem_stage_tb -o mem_stage_sim \
    && ./obj_dir/mem_stage_sim; } > sim.log 2>&1 \
  || { cat sim.log; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "ERRORS FOUND" sim.log && { echo "simulation failed"; exit 1; }
grep -q "NO ERRORS" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"

//--- sim.f
+incdir+hw
hw/cpu_pkg.sv
hw/pipe_reg.sv
hw/mem_access.sv
hw/exc_resolve.sv
hw/cp0_regs.sv
hw/data_ram.sv
hw/mem_stage_top.sv
tb/mem_stage_chk.sv
tb/mem_stage_tb.sv

//--- tb/mem_stage_chk.sv
`timescale 1ns/100ps

module mem_stage_chk (
  input logic clk,
  input logic rst,
  input logic stall_i,
  input logic flush_i,
  input logic wb_valid_i
);

  // one outstanding access, so a stall never lasts two cycles
  assert property (@(posedge clk) disable iff (rst)
    stall_i |=> !stall_i)
    else $error("stall_o high for two consecutive cycles");

  // quiet during reset and the cycle after it
  assert property (@(posedge clk)
    rst |=> (!stall_i && !flush_i && !wb_valid_i))
    else $error("stall_o, flush_o or wb_o valid not clear around reset");

endmodule

bind mem_stage_top mem_stage_chk i_mem_stage_chk (
  .clk(clk),
  .rst(rst),
  .stall_i(stall_o),
  .flush_i(flush_o),
  .wb_valid_i(wb_o.valid)
);

//--- tb/mem_stage_tb.sv
`timescale 1ns/100ps
`include "mem_macros.svh"

module mem_stage_tb;
  import cpu_pkg::*;

  // fill, stores, non-memory ops, loads, interrupt sequence, bubbles
  localparam int N_INSTR = 16 + 40 + 60 + 208 + 5 + 6;
  localparam int CYC_LIMIT = 4 * N_INSTR + 100;
  localparam logic [31:0] BASE = 32'h0000_0100;

  logic clk = 1'b0;
  logic rst;
  ex_mem_t ex_i;
  logic [5:0] hw_int_i;
  mem_wb_t wb_o;
  exc_code_e exc_code_o;
  logic [31:0] epc_o;
  logic flush_o;
  logic stall_o;

  logic [31:0] lfsr = 32'hc39b3944;
  logic [31:0] shadow [16];
  mem_wb_t exp_q [$];
  bit wdat_q [$];
  int cyc_q [$];
  int cyc = 0;
  int errors = 0;
  bit code_pend = 0;
  exc_code_e code_exp;
  bit stall_exp;
  bit epc_pend = 0;
  logic [31:0] epc_exp;
  logic [31:0] epc_next;

  mem_stage_top i_mem_stage_top (
    .clk(clk), .rst(rst), .ex_i(ex_i), .hw_int_i(hw_int_i), .wb_o(wb_o),
    .exc_code_o(exc_code_o), .epc_o(epc_o), .flush_o(flush_o), .stall_o(stall_o)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc > CYC_LIMIT) begin
      $display("timeout: run exceeded %0d cycles", CYC_LIMIT);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  // fibonacci lfsr, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    logic fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic exc_code_e exc_priority(input exc_flags_t f);
    if (f.syscall) return EXC_SYS;
    if (f.invalid) return EXC_RI;
    if (f.trap) return EXC_TR;
    if (f.overflow) return EXC_OV;
    if (f.eret) return EXC_ERET;
    return EXC_NONE;
  endfunction

  // big-endian, offset 0 is bits 31:24
  function automatic logic [31:0] extend_load(input mem_op_e op, input logic [31:0] w,
                                              input logic [1:0] off);
    logic [7:0] b;
    logic [15:0] h;
    b = w[31 - 8 * off -: 8];
    h = w[31 - 8 * off -: 16];
    case (op)
      MEM_LB:  return {{24{b[7]}}, b};
      MEM_LBU: return {24'd0, b};
      MEM_LH:  return {{16{h[15]}}, h};
      MEM_LHU: return {16'd0, h};
      default: return w;
    endcase
  endfunction

  function automatic ex_mem_t build_instr(input mem_op_e op, input logic [31:0] addr,
                                          input logic [31:0] data);
    ex_mem_t x;
    x.valid = 1'b1;
    x.wd = 5'(take_bits(5));
    x.wreg = 1'(take_bits(1));
    x.wdata = take_bits(32);
    x.whilo = 1'(take_bits(1));
    x.hi = take_bits(32);
    x.lo = take_bits(32);
    x.cp0.we = 1'(take_bits(1));
    // addresses below 8 name no implemented cp0 register
    x.cp0.addr = 5'(take_bits(3));
    x.cp0.data = take_bits(32);
    x.exc = (take_bits(3) == 0) ? 5'(take_bits(5)) : '0;
    x.in_delay = 1'(take_bits(1));
    x.pc = {30'(take_bits(30)), 2'b00};
    x.op = op;
    x.mem_addr = addr;
    x.reg2 = data;
    return x;
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (exp === act) else begin
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  // ex_q holds the previously accepted instruction here
  task automatic check_pending();
    if (epc_pend) begin
      check_val("epc", epc_exp, epc_o);
      epc_pend = 0;
    end
    if (code_pend) begin
      check_val("exc_code", 32'(code_exp), 32'(exc_code_o));
      check_val("flush", 32'(code_exp != EXC_NONE), 32'(flush_o));
      check_val("stall", 32'(stall_exp), 32'(stall_o));
      if (code_exp != EXC_NONE && code_exp != EXC_ERET) begin
        epc_exp = epc_next;
        epc_pend = 1;
      end
      code_pend = 0;
    end
  endtask

  task automatic present(input ex_mem_t x, input exc_code_e code, input logic [31:0] ld,
                         input bit chk_ld);
    bit accepted;
    bit killed;
    bit is_mem;
    int n;
    mem_wb_t e;
    ex_i <= x;
    accepted = 0;
    while (!accepted) begin
      @(negedge clk);
      check_pending();
      accepted = (stall_o === 1'b0);
      n = cyc;
      @(posedge clk);
    end
    if (x.valid) begin
      killed = (code != EXC_NONE);
      is_mem = (x.op != MEM_NONE);
      e = '0;
      e.valid = 1'b1;
      e.wd = x.wd;
      e.wreg = x.wreg && !killed;
      e.wdata = chk_ld ? ld : x.wdata;
      e.whilo = x.whilo && !killed;
      e.hi = x.hi;
      e.lo = x.lo;
      e.cp0 = x.cp0;
      e.cp0.we = x.cp0.we && !killed;
      exp_q.push_back(e);
      wdat_q.push_back(!(is_mem && killed && x.op inside {MEM_LB, MEM_LBU, MEM_LH,
                                                          MEM_LHU, MEM_LW}));
      cyc_q.push_back(n + ((is_mem && !killed) ? 3 : 2));
      code_exp = code;
      stall_exp = is_mem && !killed;
      code_pend = 1;
      epc_next = x.in_delay ? x.pc - 32'd4 : x.pc;
    end
  endtask

  task automatic run_instr(input ex_mem_t x);
    exc_code_e code;
    logic [31:0] w;
    logic [3:0] idx;
    logic [1:0] off;
    code = exc_priority(x.exc);
    idx = x.mem_addr[5:2];
    off = x.mem_addr[1:0];
    w = shadow[idx];
    if (x.op inside {MEM_LB, MEM_LBU, MEM_LH, MEM_LHU, MEM_LW}) begin
      present(x, code, extend_load(x.op, w, off), 1);
    end else begin
      present(x, code, x.wdata, 0);
    end
    if (code == EXC_NONE) begin
      case (x.op)
        MEM_SB: w[31 - 8 * off -: 8] = x.reg2[7:0];
        MEM_SH: w[31 - 8 * off -: 16] = x.reg2[15:0];
        MEM_SW: w = x.reg2;
        default: ;
      endcase
      shadow[idx] = w;
    end
  endtask

  always @(negedge clk) begin : monitor
    mem_wb_t e;
    bit w;
    int c;
    if (!rst && wb_o.valid !== 1'b0) begin
      if (exp_q.size() == 0) begin
        $display("writeback seen with no instruction outstanding");
        errors++;
      end else begin
        e = exp_q.pop_front();
        w = wdat_q.pop_front();
        c = cyc_q.pop_front();
        check_val("wb_cycle", c, cyc);
        check_val("wb_wd", 32'(e.wd), 32'(wb_o.wd));
        check_val("wb_wreg", 32'(e.wreg), 32'(wb_o.wreg));
        check_val("wb_whilo", 32'(e.whilo), 32'(wb_o.whilo));
        check_val("wb_hi", e.hi, wb_o.hi);
        check_val("wb_lo", e.lo, wb_o.lo);
        check_val("wb_cp0_we", 32'(e.cp0.we), 32'(wb_o.cp0.we));
        check_val("wb_cp0_addr", 32'(e.cp0.addr), 32'(wb_o.cp0.addr));
        check_val("wb_cp0_data", e.cp0.data, wb_o.cp0.data);
        if (w) check_val("wb_wdata", e.wdata, wb_o.wdata);
      end
    end
  end

  initial begin
    ex_mem_t x;
    mem_op_e op;
    logic [1:0] off;
    rst <= 1'b1;
    ex_i <= '0;
    hw_int_i <= '0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    for (int i = 0; i < 16; i++) begin
      x = build_instr(MEM_SW, BASE + 4 * i, take_bits(32));
      x.exc = '0;
      run_instr(x);
    end
    for (int i = 0; i < 40; i++) begin
      op = mem_op_e'(MEM_SB + take_bits(2) % 3);
      off = (op == MEM_SB) ? 2'(take_bits(2)) :
            (op == MEM_SH) ? {1'(take_bits(1)), 1'b0} : 2'd0;
      run_instr(build_instr(op, BASE + {26'd0, 4'(take_bits(4)), off}, take_bits(32)));
    end
    for (int i = 0; i < 60; i++) begin
      run_instr(build_instr(MEM_NONE, take_bits(32), take_bits(32)));
    end
    for (int i = 0; i < 16; i++) begin
      for (int o = 0; o < 4; o++) begin
        run_instr(build_instr(MEM_LB, BASE + 4 * i + o, '0));
        run_instr(build_instr(MEM_LBU, BASE + 4 * i + o, '0));
        if (o[0] == 1'b0) begin
          run_instr(build_instr(MEM_LH, BASE + 4 * i + o, '0));
          run_instr(build_instr(MEM_LHU, BASE + 4 * i + o, '0));
        end
      end
      run_instr(build_instr(MEM_LW, BASE + 4 * i, '0));
    end
    // interrupt line first, then enable IE and IM2 through a cp0 write
    hw_int_i <= 6'b000001;
    x = build_instr(MEM_NONE, '0, '0);
    x.exc = '0;
    x.cp0 = {1'b1, `CP0_STATUS, 32'h0000_0401};
    present(x, EXC_NONE, x.wdata, 0);
    // taken through the writeback forward of status
    x = build_instr(MEM_NONE, '0, '0);
    x.exc = '0;
    x.in_delay = 1'b0;
    present(x, EXC_INT, x.wdata, 0);
    // EXL masks the still pending line
    x = build_instr(MEM_NONE, '0, '0);
    x.exc = '0;
    present(x, EXC_NONE, x.wdata, 0);
    x = build_instr(MEM_NONE, '0, '0);
    x.exc = '0;
    x.exc.eret = 1'b1;
    present(x, EXC_ERET, x.wdata, 0);
    x = build_instr(MEM_NONE, '0, '0);
    x.exc = '0;
    x.in_delay = 1'b1;
    present(x, EXC_INT, x.wdata, 0);
    hw_int_i <= '0;
    for (int i = 0; i < 6; i++) begin
      present('0, EXC_NONE, '0, 0);
    end
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    $display("checks done, %0d errors", errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule
